// ==== vlog.f ====
muldiv_pkg.sv
md_control.sv
md_multiplier.sv
md_divider.sv
hilo_regs.sv
muldiv_unit.sv
tb_muldiv.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, pass only if the pass line shows up
cd "$(dirname "$0")" && \
verilator --binary -Wno-fatal --top-module tb_muldiv -f vlog.f -o sim_muldiv && \
./obj_dir/sim_muldiv | tee /dev/stderr | grep -q "TESTS PASSED" && \
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb_muldiv.sv ====
`timescale 1ns/1ns

module tb_muldiv
    import muldiv_pkg::*;
();

    localparam int RESET_CYCLES   = 4;
    // 40 worst-case ops plus reset
    localparam int TIMEOUT_CYCLES = 40 * (DIV_LAT + 5) + RESET_CYCLES;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   flush;
    logic   start;
    md_op_t op;
    word_t  a;
    word_t  b;
    word_t  hi;
    word_t  lo;
    logic   ready;

    int seed;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int cycle_count = 0;

    muldiv_unit UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .hi     (hi),
        .lo     (lo),
        .ready  (ready)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - errs_before);
        end
    endtask

    // counts falling edges with ready low
    task automatic wait_ready(output int busy);
        busy = 0;
        while (!ready) begin
            busy++;
            @(negedge clk);
        end
    endtask

    // called on a falling edge, returns on one
    task automatic issue_op(input md_op_t o, input word_t x, input word_t y, output int busy);
        start = 1'b1;
        op    = o;
        a     = x;
        b     = y;
        @(negedge clk);
        start = 1'b0;
        op    = MD_NONE;
        wait_ready(busy);
    endtask

    // low 64 bits of the product do not depend on signedness once extended
    function automatic dword_t mul_expect(input logic sgn, input word_t x, input word_t y);
        dword_t wx;
        dword_t wy;
        wx = sgn ? {{32{x[31]}}, x} : {32'h0, x};
        wy = sgn ? {{32{y[31]}}, y} : {32'h0, y};
        return wx * wy;
    endfunction

    // {remainder, quotient}, 64-bit so min / -1 does not overflow
    function automatic dword_t div_expect(input logic sgn, input word_t x, input word_t y);
        longint sx;
        longint sy;
        longint q;
        longint r;
        if (sgn) begin
            sx = longint'($signed(x));
            sy = longint'($signed(y));
        end else begin
            sx = longint'({32'h0, x});
            sy = longint'({32'h0, y});
        end
        q = sx / sy;
        r = sx % sy;
        return {r[31:0], q[31:0]};
    endfunction

    task automatic mult_and_check(input logic sgn, input word_t x, input word_t y);
        dword_t exp;
        int     busy;
        string  tag;
        exp = mul_expect(sgn, x, y);
        tag = $sformatf("%s %h * %h", sgn ? "mult" : "multu", x, y);
        issue_op(sgn ? MD_MULT : MD_MULTU, x, y, busy);
        check_equal({tag, " busy cycles"}, 64'(busy), 64'(MUL_LAT + 1));
        check_equal({tag, " hi"}, 64'(hi), 64'(exp[63:32]));
        check_equal({tag, " lo"}, 64'(lo), 64'(exp[31:0]));
    endtask

    task automatic div_and_check(input logic sgn, input word_t x, input word_t y);
        dword_t exp;
        int     busy;
        string  tag;
        exp = div_expect(sgn, x, y);
        tag = $sformatf("%s %h / %h", sgn ? "div" : "divu", x, y);
        issue_op(sgn ? MD_DIV : MD_DIVU, x, y, busy);
        check_equal({tag, " busy cycles"}, 64'(busy), 64'(DIV_LAT + 1));
        // hi = remainder, lo = quotient
        check_equal({tag, " hi"}, 64'(hi), 64'(exp[63:32]));
        check_equal({tag, " lo"}, 64'(lo), 64'(exp[31:0]));
    endtask

    task automatic reset_and_moves();
        int errs_before;
        int busy;
        errs_before = errors;
        check_equal("hi after reset", 64'(hi), 64'(0));
        check_equal("lo after reset", 64'(lo), 64'(0));
        check_equal("ready after reset", 64'(ready), 64'(1));
        issue_op(MD_MTHI, 32'h1234_5678, 32'hffff_ffff, busy);
        // moves never drop ready
        check_equal("mthi busy cycles", 64'(busy), 64'(0));
        check_equal("mthi hi", 64'(hi), 64'h1234_5678);
        check_equal("mthi lo untouched", 64'(lo), 64'(0));
        issue_op(MD_MTLO, 32'h9abc_def0, 32'h0000_0001, busy);
        check_equal("mtlo busy cycles", 64'(busy), 64'(0));
        check_equal("mtlo lo", 64'(lo), 64'h9abc_def0);
        check_equal("mtlo hi untouched", 64'(hi), 64'h1234_5678);
        report_test("reset_and_moves", errs_before);
    endtask

    task automatic multiply_ops();
        word_t corners [5];
        word_t x;
        word_t y;
        int    errs_before;
        errs_before = errors;
        corners[0] = 32'h0000_0000;
        corners[1] = 32'h0000_0001;
        corners[2] = 32'hffff_ffff;
        corners[3] = 32'h8000_0000;
        corners[4] = 32'h7fff_ffff;
        // every corner pair, signed and unsigned
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                mult_and_check(1'b1, corners[i], corners[j]);
                mult_and_check(1'b0, corners[i], corners[j]);
            end
        end
        for (int k = 0; k < 8; k++) begin
            x = $random(seed);
            y = $random(seed);
            mult_and_check(1'b1, x, y);
            mult_and_check(1'b0, x, y);
        end
        report_test("multiply_ops", errs_before);
    endtask

    task automatic divide_signs();
        word_t dvd [7];
        word_t dvs [7];
        word_t x;
        word_t y;
        int    errs_before;
        errs_before = errors;
        // all four sign combinations of 100 / 7
        dvd[0] = 32'd100;
        dvs[0] = 32'd7;
        dvd[1] = 32'hffff_ff9c;
        dvs[1] = 32'd7;
        dvd[2] = 32'd100;
        dvs[2] = 32'hffff_fff9;
        dvd[3] = 32'hffff_ff9c;
        dvs[3] = 32'hffff_fff9;
        // most negative by minus one
        dvd[4] = 32'h8000_0000;
        dvs[4] = 32'hffff_ffff;
        dvd[5] = 32'hffff_ffff;
        dvs[5] = 32'h0000_0010;
        // quotient zero
        dvd[6] = 32'd7;
        dvs[6] = 32'd100;
        for (int i = 0; i < 7; i++) begin
            div_and_check(1'b1, dvd[i], dvs[i]);
            div_and_check(1'b0, dvd[i], dvs[i]);
        end
        for (int k = 0; k < 3; k++) begin
            x = $random(seed);
            y = $random(seed);
            if (y == '0) begin
                y = 32'd1;
            end
            div_and_check(1'b1, x, y);
            div_and_check(1'b0, x, y);
        end
        report_test("divide_signs", errs_before);
    endtask

    task automatic zero_divisor();
        int errs_before;
        int busy;
        errs_before = errors;
        issue_op(MD_MTHI, 32'hdead_beef, 32'h0, busy);
        issue_op(MD_MTLO, 32'h0bad_f00d, 32'h0, busy);
        issue_op(MD_DIV, 32'h1234_5678, 32'h0, busy);
        check_equal("div by zero busy cycles", 64'(busy), 64'(DIV_LAT + 1));
        check_equal("div by zero hi kept", 64'(hi), 64'hdead_beef);
        check_equal("div by zero lo kept", 64'(lo), 64'h0bad_f00d);
        issue_op(MD_DIVU, 32'hffff_ffff, 32'h0, busy);
        check_equal("divu by zero busy cycles", 64'(busy), 64'(DIV_LAT + 1));
        check_equal("divu by zero hi kept", 64'(hi), 64'hdead_beef);
        check_equal("divu by zero lo kept", 64'(lo), 64'h0bad_f00d);
        // a normal divide right after must write back again
        div_and_check(1'b1, 32'hffff_ff00, 32'd3);
        report_test("zero_divisor", errs_before);
    endtask

    task automatic flush_and_busy_start();
        dword_t exp;
        word_t  x;
        word_t  y;
        int     errs_before;
        int     busy;
        errs_before = errors;
        issue_op(MD_MTHI, 32'h1111_2222, 32'h0, busy);
        issue_op(MD_MTLO, 32'h3333_4444, 32'h0, busy);
        // divide aborted halfway
        start = 1'b1;
        op    = MD_DIV;
        a     = 32'h7654_3210;
        b     = 32'h0000_0123;
        @(negedge clk);
        start = 1'b0;
        op    = MD_NONE;
        repeat (DIV_LAT / 2) @(negedge clk);
        check_equal("busy before flush", 64'(ready), 64'(0));
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_equal("ready after flush", 64'(ready), 64'(1));
        // past the point where the divide would have written back
        repeat (DIV_LAT) @(negedge clk);
        check_equal("flushed hi kept", 64'(hi), 64'h1111_2222);
        check_equal("flushed lo kept", 64'(lo), 64'h3333_4444);
        div_and_check(1'b0, 32'h0001_0000, 32'd3);

        // divu strobe while a mult is running
        x   = $random(seed);
        y   = $random(seed);
        exp = mul_expect(1'b1, x, y);
        start = 1'b1;
        op    = MD_MULT;
        a     = x;
        b     = y;
        @(negedge clk);
        op = MD_DIVU;
        a  = ~x;
        b  = 32'd5;
        @(negedge clk);
        start = 1'b0;
        op    = MD_NONE;
        wait_ready(busy);
        check_equal("mult with ignored start busy", 64'(busy + 1), 64'(MUL_LAT + 1));
        check_equal("mult with ignored start hi", 64'(hi), 64'(exp[63:32]));
        check_equal("mult with ignored start lo", 64'(lo), 64'(exp[31:0]));

        // mthi strobe while a divide is running
        start = 1'b1;
        op    = MD_DIV;
        a     = x;
        b     = 32'hffff_fffd;
        @(negedge clk);
        op = MD_MTHI;
        a  = 32'h5555_aaaa;
        @(negedge clk);
        start = 1'b0;
        op    = MD_NONE;
        // hi still holds the mult result
        check_equal("hi right after ignored mthi", 64'(hi), 64'(exp[63:32]));
        exp = div_expect(1'b1, x, 32'hffff_fffd);
        wait_ready(busy);
        check_equal("div with ignored mthi busy", 64'(busy + 1), 64'(DIV_LAT + 1));
        check_equal("div with ignored mthi hi", 64'(hi), 64'(exp[63:32]));
        check_equal("div with ignored mthi lo", 64'(lo), 64'(exp[31:0]));
        report_test("flush_and_busy_start", errs_before);
    endtask

    initial begin
        seed         = 32'hf48eb6f7;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        flush        = 1'b0;
        start        = 1'b0;
        op           = MD_NONE;
        a            = '0;
        b            = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        reset_and_moves();
        multiply_ops();
        divide_signs();
        zero_divisor();
        flush_and_busy_start();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== muldiv_unit.sv ====
`timescale 1ns/1ns

module muldiv_unit
    import muldiv_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    input  logic   start,
    input  md_op_t op,
    input  word_t  a,
    input  word_t  b,
    output word_t  hi,
    output word_t  lo,
    output logic   ready
);

    // control to datapath
    logic   go_mul;
    logic   go_div;
    logic   is_signed;
    word_t  opa;
    word_t  opb;

    // control to hi/lo
    logic   wb;
    logic   sel_div;
    logic   wr_hi;
    logic   wr_lo;

    // datapath results
    dword_t product;
    word_t  quotient;
    word_t  remainder;
    logic   div_zero;

    md_control u_control (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .start     (start),
        .op        (op),
        .a         (a),
        .b         (b),
        .div_zero  (div_zero),
        .ready     (ready),
        .go_mul    (go_mul),
        .go_div    (go_div),
        .is_signed (is_signed),
        .wb        (wb),
        .sel_div   (sel_div),
        .wr_hi     (wr_hi),
        .wr_lo     (wr_lo),
        .opa       (opa),
        .opb       (opb)
    );

    md_multiplier u_multiplier (
        .clk       (clk),
        .go        (go_mul),
        .is_signed (is_signed),
        .opa       (opa),
        .opb       (opb),
        .product   (product)
    );

    md_divider u_divider (
        .clk       (clk),
        .arst_n    (arst_n),
        .go        (go_div),
        .is_signed (is_signed),
        .opa       (opa),
        .opb       (opb),
        .quotient  (quotient),
        .remainder (remainder),
        .div_zero  (div_zero)
    );

    // moves take a straight from the core
    hilo_regs u_hilo (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb        (wb),
        .sel_div   (sel_div),
        .wr_hi     (wr_hi),
        .wr_lo     (wr_lo),
        .product   (product),
        .quotient  (quotient),
        .remainder (remainder),
        .a         (a),
        .hi        (hi),
        .lo        (lo)
    );

endmodule

// ==== hilo_regs.sv ====
`timescale 1ns/1ns

module hilo_regs
    import muldiv_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   wb,
    input  logic   sel_div,
    input  logic   wr_hi,
    input  logic   wr_lo,
    input  dword_t product,
    input  word_t  quotient,
    input  word_t  remainder,
    input  word_t  a,
    output word_t  hi,
    output word_t  lo
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (wb) begin
            // completed arithmetic op
            if (sel_div) begin
                // hi = remainder, lo = quotient
                hi <= remainder;
                lo <= quotient;
            end else begin
                hi <= product[63:32];
                lo <= product[31:0];
            end
        end else begin
            // mthi / mtlo, only one of them at a time
            if (wr_hi) begin
                hi <= a;
            end
            if (wr_lo) begin
                lo <= a;
            end
        end
    end

endmodule

// ==== md_divider.sv ====
`timescale 1ns/1ns

module md_divider
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  go,
    input  logic  is_signed,
    input  word_t opa,
    input  word_t opb,
    output word_t quotient,
    output word_t remainder,
    output logic  div_zero
);

    // divisor magnitude
    word_t dvs;
    // dividend shifts out the top, quotient bits shift in below
    word_t dvd;
    // partial remainder
    word_t rem;

    // result sign fixups
    logic neg_q;
    logic neg_r;

    logic             running;
    logic             fix;
    // iteration count, fits in the countdown width
    logic [CNT_W-1:0] iter;

    word_t       mag_a;
    word_t       mag_b;
    // one spare bit for the borrow
    logic [33:0] trial;

    // magnitudes, 0x80000000 stays correct as unsigned
    assign mag_a = (is_signed && opa[31]) ? -opa : opa;
    assign mag_b = (is_signed && opb[31]) ? -opb : opb;

    // shifted remainder minus divisor
    assign trial = {1'b0, rem, dvd[31]} - {2'b00, dvs};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running  <= 1'b0;
            fix      <= 1'b0;
            iter     <= '0;
            div_zero <= 1'b0;
        end else begin
            // last step done, fixup runs next cycle
            fix <= !go && running && (iter == CNT_W'(1));
            if (go) begin
                running  <= 1'b1;
                iter     <= CNT_W'(DIV_ITER);
                div_zero <= (opb == '0);
            end else if (running) begin
                iter <= iter - CNT_W'(1);
                if (iter == CNT_W'(1)) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            dvd   <= mag_a;
            dvs   <= mag_b;
            rem   <= '0;
            // truncate toward zero
            neg_q <= is_signed && (opa[31] ^ opb[31]);
            // remainder follows the dividend
            neg_r <= is_signed && opa[31];
        end else if (running) begin
            // restoring step
            if (!trial[33]) begin
                rem <= trial[31:0];
                dvd <= {dvd[30:0], 1'b1};
            end else begin
                rem <= {rem[30:0], dvd[31]};
                dvd <= {dvd[30:0], 1'b0};
            end
        end

        if (fix) begin
            quotient  <= neg_q ? -dvd : dvd;
            remainder <= neg_r ? -rem : rem;
        end
    end

endmodule

// ==== md_multiplier.sv ====
`timescale 1ns/1ns

module md_multiplier
    import muldiv_pkg::*;
(
    input  logic   clk,
    input  logic   go,
    input  logic   is_signed,
    input  word_t  opa,
    input  word_t  opb,
    output dword_t product
);

    // stage 1, operands widened to 33 bits
    logic signed [32:0] a_x;
    logic signed [32:0] b_x;

    // stage 2, 33x17 partial products
    logic signed [49:0] pp_lo;
    logic signed [49:0] pp_hi;

    // partials sign extended to full width
    logic [63:0] pp_lo_x;
    logic [63:0] pp_hi_x;

    assign pp_lo_x = {{14{pp_lo[49]}}, pp_lo};
    assign pp_hi_x = {{14{pp_hi[49]}}, pp_hi};

    always_ff @(posedge clk) begin
        // extra top bit is the sign for mult, zero for multu
        if (go) begin
            a_x <= {is_signed & opa[31], opa};
            b_x <= {is_signed & opb[31], opb};
        end

        // low half of b is always positive
        pp_lo <= a_x * $signed({1'b0, b_x[15:0]});
        // upper 17 bits carry the sign of b
        pp_hi <= a_x * $signed(b_x[32:16]);

        // recombine, result taken mod 2^64
        product <= (pp_hi_x << 16) + pp_lo_x;
    end

endmodule

// ==== md_control.sv ====
`timescale 1ns/1ns

module md_control
    import muldiv_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    input  logic   start,
    input  md_op_t op,
    input  word_t  a,
    input  word_t  b,
    input  logic   div_zero,
    output logic   ready,
    output logic   go_mul,
    output logic   go_div,
    output logic   is_signed,
    output logic   wb,
    output logic   sel_div,
    output logic   wr_hi,
    output logic   wr_lo,
    output word_t  opa,
    output word_t  opb
);

    md_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic             accept;
    logic             is_div;
    logic             is_arith;
    logic             last;

    // op decode
    assign is_div   = (op == MD_DIV) || (op == MD_DIVU);
    assign is_arith = is_div || (op == MD_MULT) || (op == MD_MULTU);

    // ready is simply "not busy"
    assign ready  = (state == MD_IDLE);
    assign accept = ready && start;

    // moves bypass the fsm, written at the accepting edge
    assign wr_hi = accept && (op == MD_MTHI);
    assign wr_lo = accept && (op == MD_MTLO);

    // count expired, result sits at the datapath output
    assign last = (state == MD_BUSY) && (cnt == '0);

    // no writeback on flush or on a zero divisor
    assign wb = last && !flush && !(sel_div && div_zero);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= MD_IDLE;
            cnt       <= '0;
            go_mul    <= 1'b0;
            go_div    <= 1'b0;
            is_signed <= 1'b0;
            sel_div   <= 1'b0;
        end else begin
            // go is a single-cycle pulse
            go_mul <= 1'b0;
            go_div <= 1'b0;
            case (state)
                MD_IDLE: begin
                    if (accept && is_arith) begin
                        state     <= MD_BUSY;
                        go_mul    <= !is_div;
                        go_div    <= is_div;
                        is_signed <= (op == MD_MULT) || (op == MD_DIV);
                        sel_div   <= is_div;
                        cnt       <= is_div ? CNT_W'(DIV_LAT) : CNT_W'(MUL_LAT);
                    end
                end
                MD_BUSY: begin
                    // flush aborts, datapath leftovers are ignored
                    if (flush || last) begin
                        state <= MD_IDLE;
                    end else begin
                        cnt <= cnt - CNT_W'(1);
                    end
                end
                default: begin
                    state <= MD_IDLE;
                end
            endcase
        end
    end

    // operand latch, held for the whole operation
    always_ff @(posedge clk) begin
        if (accept && is_arith) begin
            opa <= a;
            opb <= b;
        end
    end

endmodule

// ==== muldiv_pkg.sv ====
package muldiv_pkg;

    // one architectural register or operand
    typedef logic [31:0] word_t;

    // hi:lo pair, hi in the upper half
    typedef logic [63:0] dword_t;

    // operation selector driven with start
    typedef enum logic [2:0] {
        MD_NONE,
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU,
        MD_MTHI,
        MD_MTLO
    } md_op_t;

    // control fsm
    typedef enum logic {
        MD_IDLE,
        MD_BUSY
    } md_state_t;

    // multiplier pipeline depth
    localparam int MUL_LAT = 3;

    // quotient bits, one per cycle
    localparam int DIV_ITER = 32;

    // load + iterations + sign fixup
    localparam int DIV_LAT = DIV_ITER + 2;

    // countdown width, must hold DIV_LAT
    localparam int CNT_W = $clog2(DIV_LAT + 1);

endpackage
